//--- rtl/regfilePkg.sv
package regfilePkg;

    // storage size
    localparam int REG_COUNT  = 32;
    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = $clog2(REG_COUNT);

    // select field widths
    localparam int A_DATA_SEL_WIDTH = 4;
    localparam int A_DEST_SEL_WIDTH = 2;

    // port A data select codes
    localparam logic [A_DATA_SEL_WIDTH-1:0] RFA_RESULT_LOW = 4'd0;
    localparam logic [A_DATA_SEL_WIDTH-1:0] RFA_AREG       = 4'd1;
    localparam logic [A_DATA_SEL_WIDTH-1:0] RFA_NEXTPC     = 4'd2;
    localparam logic [A_DATA_SEL_WIDTH-1:0] RFA_SYSREG     = 4'd3;
    localparam logic [A_DATA_SEL_WIDTH-1:0] RFA_DWORD      = 4'd4;
    localparam logic [A_DATA_SEL_WIDTH-1:0] RFA_SWORD      = 4'd5;
    localparam logic [A_DATA_SEL_WIDTH-1:0] RFA_UWORD      = 4'd6;
    localparam logic [A_DATA_SEL_WIDTH-1:0] RFA_SBYTE      = 4'd7;
    localparam logic [A_DATA_SEL_WIDTH-1:0] RFA_UBYTE      = 4'd8;

    // port A destination select codes, 3 behaves as DRL
    localparam logic [A_DEST_SEL_WIDTH-1:0] RFA_DRL = 2'd0;
    localparam logic [A_DEST_SEL_WIDTH-1:0] RFA_LR  = 2'd1;
    localparam logic [A_DEST_SEL_WIDTH-1:0] RFA_EPC = 2'd2;

    // port B selects
    localparam logic RFB_RESULT_HIGH = 1'b0;
    localparam logic RFB_CALC        = 1'b1;
    localparam logic RFB_DRH         = 1'b0;
    localparam logic RFB_SRA         = 1'b1;

    // special registers
    localparam logic [ADDR_WIDTH-1:0] LR_REG  = 5'd31;
    localparam logic [ADDR_WIDTH-1:0] EPC_REG = 5'd30;

    // instruction word register fields
    localparam int DRL_MSB = 25;
    localparam int DRL_LSB = 21;
    localparam int SRA_MSB = 20;
    localparam int SRA_LSB = 16;
    localparam int SRB_MSB = 15;
    localparam int SRB_LSB = 11;
    localparam int DRH_MSB = 10;
    localparam int DRH_LSB = 6;

endpackage

//--- rtl/loadAligner.sv
`timescale 1ns/10ps

module loadAligner (
    input  logic [regfilePkg::DATA_WIDTH-1:0] dataInReg,
    input  logic [1:0]                        dataSelectBits,
    output logic [15:0]                       dataWord,
    output logic [7:0]                        dataByte
);

    logic [15:0] upperHalf;
    logic [15:0] lowerHalf;

    assign upperHalf = dataInReg[31:16];
    assign lowerHalf = dataInReg[15:0];

    // halfword, bit 1 low picks the upper half
    always_comb begin
        if (dataSelectBits[1]) begin
            dataWord = lowerHalf;
        end else begin
            dataWord = upperHalf;
        end
    end

    // byte lanes counted from the most significant end
    always_comb begin
        case (dataSelectBits)
            2'b00: begin
                dataByte = dataInReg[31:24];
            end
            2'b01: begin
                dataByte = dataInReg[23:16];
            end
            2'b10: begin
                dataByte = dataInReg[15:8];
            end
            default: begin
                dataByte = dataInReg[7:0];
            end
        endcase
    end

endmodule

//--- rtl/writeBackSelect.sv
`timescale 1ns/10ps

module writeBackSelect (
    input  logic                                    exceptionPending,
    input  logic                                    writeEnA,
    input  logic [regfilePkg::A_DATA_SEL_WIDTH-1:0] dataSelA,
    input  logic [regfilePkg::A_DEST_SEL_WIDTH-1:0] destSelA,
    input  logic                                    writeEnB,
    input  logic                                    dataSelB,
    input  logic                                    destSelB,
    input  logic [regfilePkg::DATA_WIDTH-1:0]       instructionReg,
    input  logic [regfilePkg::DATA_WIDTH-1:0]       resultLow,
    input  logic [regfilePkg::DATA_WIDTH-1:0]       aRegister,
    input  logic [regfilePkg::DATA_WIDTH-1:0]       nextPC,
    input  logic [regfilePkg::DATA_WIDTH-1:0]       systemRegister,
    input  logic [regfilePkg::DATA_WIDTH-1:0]       dataInReg,
    input  logic [15:0]                             dataWord,
    input  logic [7:0]                              dataByte,
    input  logic [regfilePkg::DATA_WIDTH-1:0]       resultHigh,
    input  logic [regfilePkg::DATA_WIDTH-1:0]       calculatedAddress,
    output logic                                    portAEn,
    output logic [regfilePkg::ADDR_WIDTH-1:0]       portAAddr,
    output logic [regfilePkg::DATA_WIDTH-1:0]       portAData,
    output logic                                    portBEn,
    output logic [regfilePkg::ADDR_WIDTH-1:0]       portBAddr,
    output logic [regfilePkg::DATA_WIDTH-1:0]       portBData
);

    import regfilePkg::*;

    // a pending exception cancels write-back on both ports
    assign portAEn = writeEnA & ~exceptionPending;
    assign portBEn = writeEnB & ~exceptionPending;

    // port A data, loads extended here
    always_comb begin
        case (dataSelA)
            RFA_AREG:   portAData = aRegister;
            RFA_NEXTPC: portAData = nextPC;
            RFA_SYSREG: portAData = systemRegister;
            RFA_DWORD:  portAData = dataInReg;
            RFA_SWORD:  portAData = {{16{dataWord[15]}}, dataWord};
            RFA_UWORD:  portAData = {16'b0, dataWord};
            RFA_SBYTE:  portAData = {{24{dataByte[7]}}, dataByte};
            RFA_UBYTE:  portAData = {24'b0, dataByte};
            default:    portAData = resultLow;
        endcase
    end

    // port A destination
    always_comb begin
        case (destSelA)
            RFA_LR:  portAAddr = LR_REG;
            RFA_EPC: portAAddr = EPC_REG;
            default: portAAddr = instructionReg[DRL_MSB:DRL_LSB];
        endcase
    end

    // port B data and destination
    assign portBData = (dataSelB == RFB_CALC) ? calculatedAddress : resultHigh;

    // address write-back goes to the base register
    assign portBAddr = (destSelB == RFB_SRA) ? instructionReg[SRA_MSB:SRA_LSB]
                                             : instructionReg[DRH_MSB:DRH_LSB];

endmodule

//--- rtl/dualWriteRegfile.sv
`timescale 1ns/10ps

module dualWriteRegfile (
    input  logic                              clk,
    input  logic                              arstN,
    input  logic                              portAEn,
    input  logic [regfilePkg::ADDR_WIDTH-1:0] portAAddr,
    input  logic [regfilePkg::DATA_WIDTH-1:0] portAData,
    input  logic                              portBEn,
    input  logic [regfilePkg::ADDR_WIDTH-1:0] portBAddr,
    input  logic [regfilePkg::DATA_WIDTH-1:0] portBData,
    input  logic [regfilePkg::ADDR_WIDTH-1:0] readAddrA,
    input  logic [regfilePkg::ADDR_WIDTH-1:0] readAddrB,
    output logic [regfilePkg::DATA_WIDTH-1:0] readDataA,
    output logic [regfilePkg::DATA_WIDTH-1:0] readDataB
);

    import regfilePkg::*;

    logic [DATA_WIDTH-1:0] regs [REG_COUNT];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (portBEn) begin
                regs[portBAddr] <= portBData;
            end
            // port A assigned last so it wins a collision
            if (portAEn) begin
                regs[portAAddr] <= portAData;
            end
        end
    end

    // no bypass, a write shows up the cycle after
    assign readDataA = regs[readAddrA];
    assign readDataB = regs[readAddrB];

endmodule

//--- rtl/registerFile.sv
`timescale 1ns/10ps

module registerFile (
    input  logic                                    clk,
    input  logic                                    arstN,
    input  logic                                    exceptionPending,
    input  logic                                    writeEnA,
    input  logic [regfilePkg::A_DATA_SEL_WIDTH-1:0] dataSelA,
    input  logic [regfilePkg::A_DEST_SEL_WIDTH-1:0] destSelA,
    input  logic                                    writeEnB,
    input  logic                                    dataSelB,
    input  logic                                    destSelB,
    input  logic [1:0]                              dataSelectBits,
    input  logic [regfilePkg::DATA_WIDTH-1:0]       dataInReg,
    input  logic [regfilePkg::DATA_WIDTH-1:0]       resultLow,
    input  logic [regfilePkg::DATA_WIDTH-1:0]       aRegister,
    input  logic [regfilePkg::DATA_WIDTH-1:0]       nextPC,
    input  logic [regfilePkg::DATA_WIDTH-1:0]       systemRegister,
    input  logic [regfilePkg::DATA_WIDTH-1:0]       resultHigh,
    input  logic [regfilePkg::DATA_WIDTH-1:0]       calculatedAddress,
    input  logic [regfilePkg::DATA_WIDTH-1:0]       instructionReg,
    output logic [regfilePkg::DATA_WIDTH-1:0]       readDataA,
    output logic [regfilePkg::DATA_WIDTH-1:0]       readDataB
);

    import regfilePkg::*;

    logic [15:0]           dataWord;
    logic [7:0]            dataByte;
    logic                  portAEn;
    logic [ADDR_WIDTH-1:0] portAAddr;
    logic [DATA_WIDTH-1:0] portAData;
    logic                  portBEn;
    logic [ADDR_WIDTH-1:0] portBAddr;
    logic [DATA_WIDTH-1:0] portBData;

    loadAligner uLoadAligner (
        .dataInReg,
        .dataSelectBits,
        .dataWord,
        .dataByte
    );

    writeBackSelect uWriteBackSelect (
        .exceptionPending,
        .writeEnA,
        .dataSelA,
        .destSelA,
        .writeEnB,
        .dataSelB,
        .destSelB,
        .instructionReg,
        .resultLow,
        .aRegister,
        .nextPC,
        .systemRegister,
        .dataInReg,
        .dataWord,
        .dataByte,
        .resultHigh,
        .calculatedAddress,
        .portAEn,
        .portAAddr,
        .portAData,
        .portBEn,
        .portBAddr,
        .portBData
    );

    // read addresses come straight from the instruction
    dualWriteRegfile uDualWriteRegfile (
        .clk,
        .arstN,
        .portAEn,
        .portAAddr,
        .portAData,
        .portBEn,
        .portBAddr,
        .portBData,
        .readAddrA (instructionReg[SRA_MSB:SRA_LSB]),
        .readAddrB (instructionReg[SRB_MSB:SRB_LSB]),
        .readDataA,
        .readDataB
    );

endmodule

//--- sim/registerFileChecker.sv
`timescale 1ns/10ps

module registerFileChecker (
    input logic                                    clk,
    input logic                                    arstN,
    input logic                                    exceptionPending,
    input logic [regfilePkg::A_DEST_SEL_WIDTH-1:0] destSelA,
    input logic                                    portAEn,
    input logic                                    portBEn,
    input logic [regfilePkg::ADDR_WIDTH-1:0]       portAAddr,
    input logic [regfilePkg::DATA_WIDTH-1:0]       readDataA
);

    import regfilePkg::*;

    int failCount = 0;

    exceptionGatesWrites: assert property (@(posedge clk) disable iff (!arstN)
        exceptionPending |-> (!portAEn && !portBEn))
    else begin
        $error("a write enable is active while an exception is pending");
        failCount++;
    end

    linkRegisterAddress: assert property (@(posedge clk) disable iff (!arstN)
        (destSelA == RFA_LR) |-> (portAAddr == LR_REG))
    else begin
        $error("link register destination does not address register 31");
        failCount++;
    end

    // storage must read zero during reset
    resetReadsZero: assert property (@(posedge clk) !arstN |-> (readDataA == '0))
    else begin
        $error("read port A is not zero while reset is asserted");
        failCount++;
    end

endmodule

//--- sim/registerFileMonitor.sv
`timescale 1ns/10ps

module registerFileMonitor (
    input  logic        clk,
    input  logic        arstN,
    input  logic        checkEn,
    input  logic [31:0] readDataA,
    input  logic [31:0] readDataB,
    input  logic [31:0] expReadDataA,
    input  logic [31:0] expReadDataB,
    output int          mismatchCount,
    output int          checkCount
);

    task automatic compareRead(
        input string       name,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        checkCount++;
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s expected %08h, got %08h",
                     $time, name, expected, actual);
            mismatchCount++;
        end
    endtask

    // storage updates after this edge, so reads still show the old state
    always @(posedge clk) begin
        if (!arstN) begin
            mismatchCount = 0;
            checkCount = 0;
        end else if (checkEn) begin
            compareRead("readDataA", expReadDataA, readDataA);
            compareRead("readDataB", expReadDataB, readDataB);
        end
    end

endmodule

//--- sim/registerFileTb.sv
`timescale 1ns/10ps

module registerFileTb;

    import regfilePkg::*;

    localparam int RESET_CYCLES    = 5;
    localparam int RELEASE_TIMEOUT = 10;
    localparam int RUN_TIMEOUT_NS  = 20000;

    typedef struct packed {
        logic        exception;
        logic        weA;
        logic [3:0]  dselA;
        logic [1:0]  destA;
        logic        weB;
        logic        dselB;
        logic        destB;
        logic [1:0]  dsb;
        logic [4:0]  drl;
        logic [4:0]  sra;
        logic [4:0]  srb;
        logic [4:0]  drh;
        logic [31:0] expA;
        logic [31:0] expB;
    } stimRowT;

    logic        clk;
    logic        arstN;
    logic        exceptionPending;
    logic        writeEnA;
    logic [3:0]  dataSelA;
    logic [1:0]  destSelA;
    logic        writeEnB;
    logic        dataSelB;
    logic        destSelB;
    logic [1:0]  dataSelectBits;
    logic [31:0] dataInReg;
    logic [31:0] resultLow;
    logic [31:0] aRegister;
    logic [31:0] nextPC;
    logic [31:0] systemRegister;
    logic [31:0] resultHigh;
    logic [31:0] calculatedAddress;
    logic [31:0] instructionReg;
    logic [31:0] readDataA;
    logic [31:0] readDataB;
    logic        checkEn;
    logic [31:0] expReadDataA;
    logic [31:0] expReadDataB;
    int          mismatchCount;
    int          checkCount;
    int          otherErrors;
    logic        runDone;
    stimRowT     stimTable[$];
    logic [31:0] shadow [32];

    registerFile i_dut (.*);

    registerFileMonitor uMonitor (
        .clk          (clk),
        .arstN        (arstN),
        .checkEn      (checkEn),
        .readDataA    (readDataA),
        .readDataB    (readDataB),
        .expReadDataA (expReadDataA),
        .expReadDataB (expReadDataB),
        .mismatchCount(mismatchCount),
        .checkCount   (checkCount)
    );

    bind registerFile registerFileChecker uChecker (
        .clk             (clk),
        .arstN           (arstN),
        .exceptionPending(exceptionPending),
        .destSelA        (destSelA),
        .portAEn         (portAEn),
        .portBEn         (portBEn),
        .portAAddr       (portAAddr),
        .readDataA       (readDataA)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic appendRow(
        input logic exception, input logic weA, input logic [3:0] dselA, input logic [1:0] destA,
        input logic weB, input logic dselB, input logic destB, input logic [1:0] dsb,
        input logic [4:0] drl, input logic [4:0] sra, input logic [4:0] srb, input logic [4:0] drh
    );
        stimRowT row;
        row = '{exception, weA, dselA, destA, weB, dselB, destB, dsb, drl, sra, srb, drh, 0, 0};
        stimTable.push_back(row);
    endtask

    task automatic buildTable();
        int target;
        // reset state on both read ports
        for (int i = 0; i < 32; i++) begin
            appendRow(0, 0, RFA_RESULT_LOW, RFA_DRL, 0, RFB_RESULT_HIGH, RFB_DRH, 0, 0,
                      5'(i), 5'(31 - i), 0);
        end
        // each write row reads its own target (old) and the previous target (new)
        target = 1;
        for (int sel = 0; sel <= 4; sel++) begin
            appendRow(0, 1, 4'(sel), RFA_DRL, 0, 0, 0, 0,
                      5'(target), 5'(target), 5'(target - 1), 0);
            target++;
        end
        for (int sel = int'(RFA_SWORD); sel <= int'(RFA_UBYTE); sel++) begin
            for (int dsb = 0; dsb < 4; dsb++) begin
                appendRow(0, 1, 4'(sel), RFA_DRL, 0, 0, 0, 2'(dsb),
                          5'(target), 5'(target), 5'(target - 1), 0);
                target++;
            end
        end
        // unused codes fall back to low result and DRL
        appendRow(0, 1, 4'd9, RFA_DRL, 0, 0, 0, 0, 22, 22, 21, 0);
        appendRow(0, 1, RFA_AREG, 2'd3, 0, 0, 0, 0, 23, 23, 22, 0);
        appendRow(0, 1, RFA_NEXTPC, RFA_LR, 0, 0, 0, 0, 7, 31, 23, 0);
        appendRow(0, 1, RFA_SYSREG, RFA_EPC, 0, 0, 0, 0, 8, 30, 31, 0);
        appendRow(0, 0, RFA_RESULT_LOW, RFA_DRL, 1, RFB_RESULT_HIGH, RFB_DRH, 0, 0, 30, 24, 24);
        appendRow(0, 0, RFA_RESULT_LOW, RFA_DRL, 1, RFB_CALC, RFB_SRA, 0, 0, 25, 24, 0);
        // same address on both ports
        appendRow(0, 1, RFA_AREG, RFA_DRL, 1, RFB_RESULT_HIGH, RFB_DRH, 0, 26, 26, 25, 26);
        appendRow(0, 1, RFA_RESULT_LOW, RFA_DRL, 1, RFB_CALC, RFB_DRH, 0, 27, 29, 26, 28);
        // pending exception
        appendRow(1, 1, RFA_AREG, RFA_DRL, 1, RFB_RESULT_HIGH, RFB_DRH, 0, 1, 1, 27, 2);
        appendRow(1, 1, RFA_NEXTPC, RFA_LR, 1, RFB_CALC, RFB_SRA, 0, 0, 3, 28, 0);
        appendRow(0, 0, RFA_RESULT_LOW, RFA_DRL, 0, 0, 0, 0, 0, 1, 2, 0);
        for (int i = 0; i < 16; i++) begin
            appendRow(0, 0, RFA_RESULT_LOW, RFA_DRL, 0, 0, 0, 0, 0, 5'(i), 5'(31 - i), 0);
        end
    endtask

    function automatic logic [31:0] modelPortAData(
        input logic [3:0] sel, input logic [1:0] dsb, input logic [31:0] low,
        input logic [31:0] aReg, input logic [31:0] pc, input logic [31:0] sysReg,
        input logic [31:0] loadWord
    );
        logic [15:0] half;
        logic [7:0]  loadByte;
        half = 16'(loadWord >> (dsb[1] ? 0 : 16));
        loadByte = 8'(loadWord >> (8 * (3 - int'(dsb))));
        case (sel)
            RFA_AREG:   return aReg;
            RFA_NEXTPC: return pc;
            RFA_SYSREG: return sysReg;
            RFA_DWORD:  return loadWord;
            RFA_SWORD:  return 32'($signed(half));
            RFA_UWORD:  return 32'(half);
            RFA_SBYTE:  return 32'($signed(loadByte));
            RFA_UBYTE:  return 32'(loadByte);
            default:    return low;
        endcase
    endfunction

    task automatic driveIdle();
        exceptionPending = 1'b0;
        writeEnA = 1'b0;
        dataSelA = '0;
        destSelA = '0;
        writeEnB = 1'b0;
        dataSelB = 1'b0;
        destSelB = 1'b0;
        dataSelectBits = '0;
        dataInReg = '0;
        resultLow = '0;
        aRegister = '0;
        nextPC = '0;
        systemRegister = '0;
        resultHigh = '0;
        calculatedAddress = '0;
        instructionReg = '0;
    endtask

    task automatic applyRow(input int index);
        stimRowT     row;
        logic [31:0] loadWord;
        logic [3:0]  laneTop;
        logic [31:0] instr;
        logic [31:0] aData;
        logic [4:0]  aAddr;
        logic [31:0] bData;
        logic [4:0]  bAddr;
        row = stimTable[index];
        // top bit of the addressed lane is the opposite of every other lane
        if (row.dselA == RFA_SWORD || row.dselA == RFA_UWORD) begin
            laneTop = row.dsb[1] ? 4'b0010 : 4'b1000;
        end else begin
            laneTop = 4'b1000 >> row.dsb;
        end
        if (index % 2 == 0) begin
            laneTop = ~laneTop;
        end
        loadWord = $urandom;
        loadWord = (loadWord & 32'h7f7f_7f7f)
                 | {laneTop[3], 7'b0, laneTop[2], 7'b0, laneTop[1], 7'b0, laneTop[0], 7'b0};
        instr = $urandom;
        instr[DRL_MSB:DRL_LSB] = row.drl;
        instr[SRA_MSB:SRA_LSB] = row.sra;
        instr[SRB_MSB:SRB_LSB] = row.srb;
        instr[DRH_MSB:DRH_LSB] = row.drh;
        resultLow = $urandom;
        aRegister = $urandom;
        nextPC = $urandom;
        systemRegister = $urandom;
        resultHigh = $urandom;
        calculatedAddress = $urandom;
        dataInReg = loadWord;
        instructionReg = instr;
        exceptionPending = row.exception;
        writeEnA = row.weA;
        dataSelA = row.dselA;
        destSelA = row.destA;
        writeEnB = row.weB;
        dataSelB = row.dselB;
        destSelB = row.destB;
        dataSelectBits = row.dsb;
        row.expA = shadow[row.sra];
        row.expB = shadow[row.srb];
        stimTable[index] = row;
        expReadDataA = row.expA;
        expReadDataB = row.expB;
        checkEn = 1'b1;
        aData = modelPortAData(row.dselA, row.dsb, resultLow, aRegister, nextPC,
                               systemRegister, loadWord);
        aAddr = (row.destA == RFA_LR) ? LR_REG : (row.destA == RFA_EPC) ? EPC_REG : row.drl;
        bData = (row.dselB == RFB_CALC) ? calculatedAddress : resultHigh;
        bAddr = (row.destB == RFB_SRA) ? row.sra : row.drh;
        if (!row.exception) begin
            if (row.weB) begin
                shadow[bAddr] = bData;
            end
            // port A wins a collision
            if (row.weA) begin
                shadow[aAddr] = aData;
            end
        end
    endtask

    initial begin : mainSequence
        int   waitCount;
        logic released;
        int   totalErrors;
        void'($urandom(1944));
        driveIdle();
        arstN = 1'b0;
        checkEn = 1'b0;
        expReadDataA = '0;
        expReadDataB = '0;
        otherErrors = 0;
        runDone = 1'b0;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        buildTable();
        repeat (RESET_CYCLES) @(posedge clk);
        #1 arstN = 1'b1;
        released = 1'b0;
        waitCount = 0;
        while (!released && waitCount < RELEASE_TIMEOUT) begin
            @(posedge clk);
            waitCount++;
            released = (arstN === 1'b1);
        end
        if (!released) begin
            $display("reset was not released within %0d cycles", RELEASE_TIMEOUT);
            otherErrors++;
        end
        for (int i = 0; i < stimTable.size(); i++) begin
            #1;
            applyRow(i);
            @(posedge clk);
        end
        #1;
        checkEn = 1'b0;
        driveIdle();
        @(posedge clk);
        #1;
        runDone = 1'b1;
        totalErrors = mismatchCount + otherErrors + i_dut.uChecker.failCount;
        $display("checks %0d, mismatches %0d, other errors %0d, assertion failures %0d",
                 checkCount, mismatchCount, otherErrors, i_dut.uChecker.failCount);
        if (totalErrors == 0 && checkCount > 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // overall run limit
    initial begin
        while (runDone !== 1'b1 && $time < RUN_TIMEOUT_NS) begin
            #10;
        end
        if (runDone !== 1'b1) begin
            otherErrors++;
            $display("run did not finish within %0d ns", RUN_TIMEOUT_NS);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

endmodule

//--- regfileWb.f
rtl/regfilePkg.sv
rtl/loadAligner.sv
rtl/writeBackSelect.sv
rtl/dualWriteRegfile.sv
rtl/registerFile.sv
sim/registerFileChecker.sv
sim/registerFileMonitor.sv
sim/registerFileTb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall
TOP       ?= registerFileTb
FILELIST  ?= regfileWb.f
OBJDIR    ?= obj_dir
PASS_MSG  := TESTBENCH PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
